/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_bus_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "tests failed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	elif grep -qx "all tests passed" $(LOG); then \
		echo "simulation PASSED"; \
	else \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
bus_pkg.sv
bus_lane_align.sv
bus_clint.sv
bus_arbiter.sv
bus_top.sv
tb_axi_mem.sv
tb_bus_chk.sv
tb_bus_top.sv

/* bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
  input  logic clk,
  input  logic rst,
  input  logic ifu_arvalid_i,
  input  logic lsu_arvalid_i,
  input  logic lsu_awvalid_i,
  input  logic rtc_hit_i,
  input  logic io_arready_i,
  input  logic io_rvalid_i,
  input  logic io_awready_i,
  input  logic io_wready_i,
  input  logic io_bvalid_i,
  output logic io_arvalid_o,
  output logic io_awvalid_o,
  output logic io_wvalid_o,
  output logic sel_lsu_o,
  output logic rtc_req_o,
  output logic ifu_rvalid_o,
  output logic lsu_rvalid_o,
  output logic lsu_wready_o,
  input  logic rtc_rvalid_i
);

  bus_pkg::arb_state_e state_q;
  bus_pkg::arb_state_e state_d;

  logic ifu_ar_q;   // fetch AR raised but not yet taken
  logic aw_done_q;
  logic w_done_q;
  logic ls_req;
  logic aw_ok;
  logic w_ok;
  logic wr_phase;

  assign ls_req   = lsu_arvalid_i || lsu_awvalid_i;
  assign aw_ok    = aw_done_q || io_awready_i;
  assign w_ok     = w_done_q || io_wready_i;
  assign wr_phase = (state_q == bus_pkg::LS_ADDR) && !lsu_arvalid_i && lsu_awvalid_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      bus_pkg::IF_ADDR:
      begin
        if (io_arvalid_o && io_arready_i)
          state_d = bus_pkg::IF_DATA;
        else if (ls_req && !ifu_ar_q)  // load/store wins unless fetch AR is out
          state_d = bus_pkg::LS_ADDR;
      end
      bus_pkg::IF_DATA:
      begin
        if (io_rvalid_i)
          state_d = bus_pkg::IF_ADDR;
      end
      bus_pkg::LS_ADDR:
      begin
        if (lsu_arvalid_i)
        begin
          if (rtc_hit_i || io_arready_i)
            state_d = bus_pkg::LS_RDATA;
        end
        else if (lsu_awvalid_i)
        begin
          if (aw_ok && w_ok)
            state_d = bus_pkg::LS_WRESP;
        end
        else
          state_d = bus_pkg::IF_ADDR;
      end
      bus_pkg::LS_RDATA:
      begin
        if (io_rvalid_i || rtc_rvalid_i)
          state_d = bus_pkg::IF_ADDR;
      end
      bus_pkg::LS_WRESP:
      begin
        if (io_bvalid_i)
          state_d = bus_pkg::IF_ADDR;
      end
      default:
        state_d = bus_pkg::IF_ADDR;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= bus_pkg::IF_ADDR;
      ifu_ar_q  <= 1'b0;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end
    else
    begin
      state_q   <= state_d;
      ifu_ar_q  <= (state_q == bus_pkg::IF_ADDR) && io_arvalid_o && !io_arready_i;
      // remember the half of the write that got through first
      aw_done_q <= wr_phase && aw_ok && !w_ok;
      w_done_q  <= wr_phase && w_ok && !aw_ok;
    end
  end

  assign io_arvalid_o = ((state_q == bus_pkg::IF_ADDR) && ifu_arvalid_i &&
                         (ifu_ar_q || !ls_req)) ||
                        ((state_q == bus_pkg::LS_ADDR) && lsu_arvalid_i && !rtc_hit_i);
  assign io_awvalid_o = wr_phase && !aw_done_q;
  assign io_wvalid_o  = wr_phase && !w_done_q;

  assign sel_lsu_o = (state_q == bus_pkg::LS_ADDR) ||
                     (state_q == bus_pkg::LS_RDATA) ||
                     (state_q == bus_pkg::LS_WRESP);
  assign rtc_req_o = (state_q == bus_pkg::LS_ADDR) && lsu_arvalid_i && rtc_hit_i;

  // reply pulses, one requester at a time
  assign ifu_rvalid_o = (state_q == bus_pkg::IF_DATA) && io_rvalid_i;
  assign lsu_rvalid_o = (state_q == bus_pkg::LS_RDATA) && (io_rvalid_i || rtc_rvalid_i);
  assign lsu_wready_o = (state_q == bus_pkg::LS_WRESP) && io_bvalid_i;

endmodule

/* bus_clint.sv */
`timescale 1ns/1ps

module bus_clint #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] araddr_i,
  input  logic              arvalid_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic              rvalid_o
);

  logic [63:0] mtime_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q  <= '0;
      rvalid_o <= 1'b0;
    end
    else
    begin
      mtime_q  <= mtime_q + 64'd1;  // free running
      rvalid_o <= arvalid_i;
    end
  end

  // word sampled in the request cycle
  always_ff @(posedge clk)
  begin
    if (arvalid_i)
    begin
      if (araddr_i == ADDR_W'(bus_pkg::RTC_ADDR_UP))
        rdata_o <= mtime_q[DATA_W +: DATA_W];
      else
        rdata_o <= mtime_q[DATA_W-1:0];
    end
  end

endmodule

/* bus_lane_align.sv */
`timescale 1ns/1ps

module bus_lane_align #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                              sel_lsu_i,
  input  logic [ADDR_W-1:0]                 ifu_araddr_i,
  input  logic [ADDR_W-1:0]                 lsu_araddr_i,
  input  logic [DATA_W/8-1:0]               lsu_rstrb_i,
  input  logic [ADDR_W-1:0]                 lsu_awaddr_i,
  input  logic [DATA_W-1:0]                 lsu_wdata_i,
  input  logic [DATA_W/8-1:0]               lsu_wstrb_i,
  input  logic [bus_pkg::BUS_DATA_W-1:0]    io_rdata_i,
  input  logic [DATA_W-1:0]                 rtc_rdata_i,
  output logic [ADDR_W-1:0]                 io_araddr_o,
  output logic [2:0]                        io_arsize_o,
  output logic [ADDR_W-1:0]                 io_awaddr_o,
  output logic [2:0]                        io_awsize_o,
  output logic [bus_pkg::BUS_DATA_W-1:0]    io_wdata_o,
  output logic [bus_pkg::BUS_DATA_W/8-1:0]  io_wstrb_o,
  output logic [DATA_W-1:0]                 rdata_o,
  output logic                              rtc_hit_o
);

  localparam int STRB_W = DATA_W / 8;

  logic [ADDR_W-1:0] rd_addr;
  logic [1:0]        wr_off;
  logic [DATA_W-1:0] wdata_sh;
  logic [STRB_W-1:0] wstrb_sh;

  function automatic logic [2:0] size_of(input logic [STRB_W-1:0] strb);
    logic [2:0] size;
    case (strb)
      'h1:     size = bus_pkg::AXI_SIZE_B;
      'h3:     size = bus_pkg::AXI_SIZE_H;
      'hf:     size = bus_pkg::AXI_SIZE_W;
      default: size = bus_pkg::AXI_SIZE_B;
    endcase
    return size;
  endfunction

  assign rd_addr     = sel_lsu_i ? lsu_araddr_i : ifu_araddr_i;
  assign io_araddr_o = rd_addr;
  assign io_arsize_o = sel_lsu_i ? size_of(lsu_rstrb_i) : bus_pkg::AXI_SIZE_W; // fetch is a word

  assign rtc_hit_o = (lsu_araddr_i == ADDR_W'(bus_pkg::RTC_ADDR)) ||
                     (lsu_araddr_i == ADDR_W'(bus_pkg::RTC_ADDR_UP));

  always_comb
  begin
    if (sel_lsu_i && rtc_hit_o)
      rdata_o = rtc_rdata_i;
    else if (rd_addr[2])
      rdata_o = io_rdata_i[bus_pkg::BUS_DATA_W-1 -: DATA_W];
    else
      rdata_o = io_rdata_i[DATA_W-1:0];
  end

  // stores: move data and strobe up to the byte offset
  assign wr_off      = lsu_awaddr_i[1:0];
  assign wdata_sh    = lsu_wdata_i << {wr_off, 3'b000};
  assign wstrb_sh    = lsu_wstrb_i << wr_off;
  assign io_awaddr_o = lsu_awaddr_i;
  assign io_awsize_o = size_of(lsu_wstrb_i);
  assign io_wdata_o  = {2{wdata_sh}};  // same word in both halves
  assign io_wstrb_o  = lsu_awaddr_i[2] ? {wstrb_sh, {STRB_W{1'b0}}}
                                       : {{STRB_W{1'b0}}, wstrb_sh};

endmodule

/* bus_pkg.sv */
package bus_pkg;

  // arbiter FSM, fetch side first
  typedef enum logic [2:0] {
    IF_ADDR,
    IF_DATA,
    LS_ADDR,
    LS_RDATA,
    LS_WRESP
  } arb_state_e;

  // mtime low and high word, served by the local timer
  localparam logic [31:0] RTC_ADDR    = 32'h0200_bff8;
  localparam logic [31:0] RTC_ADDR_UP = 32'h0200_bffc;

  // axsize codes
  localparam logic [2:0] AXI_SIZE_B = 3'b000;
  localparam logic [2:0] AXI_SIZE_H = 3'b001;
  localparam logic [2:0] AXI_SIZE_W = 3'b010;

  localparam int BUS_DATA_W = 64;  // half select relies on this

endpackage

/* bus_top.sv */
`timescale 1ns/1ps

module bus_top #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [ADDR_W-1:0]                 ifu_araddr_i,
  input  logic                              ifu_arvalid_i,
  output logic [DATA_W-1:0]                 ifu_rdata_o,
  output logic                              ifu_rvalid_o,
  input  logic [ADDR_W-1:0]                 lsu_araddr_i,
  input  logic                              lsu_arvalid_i,
  input  logic [DATA_W/8-1:0]               lsu_rstrb_i,
  output logic [DATA_W-1:0]                 lsu_rdata_o,
  output logic                              lsu_rvalid_o,
  input  logic [ADDR_W-1:0]                 lsu_awaddr_i,
  input  logic                              lsu_awvalid_i,
  input  logic [DATA_W-1:0]                 lsu_wdata_i,
  input  logic [DATA_W/8-1:0]               lsu_wstrb_i,
  output logic                              lsu_wready_o,
  output logic [1:0]                        io_master_arburst_o,
  output logic [2:0]                        io_master_arsize_o,
  output logic [7:0]                        io_master_arlen_o,
  output logic [3:0]                        io_master_arid_o,
  output logic [ADDR_W-1:0]                 io_master_araddr_o,
  output logic                              io_master_arvalid_o,
  input  logic                              io_master_arready_i,
  input  logic [bus_pkg::BUS_DATA_W-1:0]    io_master_rdata_i,
  input  logic [1:0]                        io_master_rresp_i,
  input  logic                              io_master_rvalid_i,
  output logic                              io_master_rready_o,
  output logic [1:0]                        io_master_awburst_o,
  output logic [2:0]                        io_master_awsize_o,
  output logic [7:0]                        io_master_awlen_o,
  output logic [3:0]                        io_master_awid_o,
  output logic [ADDR_W-1:0]                 io_master_awaddr_o,
  output logic                              io_master_awvalid_o,
  input  logic                              io_master_awready_i,
  output logic                              io_master_wlast_o,
  output logic [bus_pkg::BUS_DATA_W-1:0]    io_master_wdata_o,
  output logic [bus_pkg::BUS_DATA_W/8-1:0]  io_master_wstrb_o,
  output logic                              io_master_wvalid_o,
  input  logic                              io_master_wready_i,
  input  logic [1:0]                        io_master_bresp_i,
  input  logic                              io_master_bvalid_i,
  output logic                              io_master_bready_o
);

  logic              sel_lsu;
  logic              rtc_hit;
  logic              rtc_req;
  logic              rtc_rvalid;
  logic [DATA_W-1:0] rtc_rdata;
  logic [DATA_W-1:0] rdata;

  // single beat, id 0, incr
  assign io_master_arburst_o = 2'b01;
  assign io_master_arlen_o   = 8'd0;
  assign io_master_arid_o    = 4'd0;
  assign io_master_awburst_o = 2'b01;
  assign io_master_awlen_o   = 8'd0;
  assign io_master_awid_o    = 4'd0;
  assign io_master_wlast_o   = 1'b1;
  assign io_master_rready_o  = 1'b1;
  assign io_master_bready_o  = 1'b1;

  assign ifu_rdata_o = rdata;  // qualified by ifu_rvalid_o
  assign lsu_rdata_o = rdata;

  bus_arbiter u_arbiter (
    .clk           (clk),
    .rst           (rst),
    .ifu_arvalid_i (ifu_arvalid_i),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_awvalid_i (lsu_awvalid_i),
    .rtc_hit_i     (rtc_hit),
    .io_arready_i  (io_master_arready_i),
    .io_rvalid_i   (io_master_rvalid_i),
    .io_awready_i  (io_master_awready_i),
    .io_wready_i   (io_master_wready_i),
    .io_bvalid_i   (io_master_bvalid_i),
    .io_arvalid_o  (io_master_arvalid_o),
    .io_awvalid_o  (io_master_awvalid_o),
    .io_wvalid_o   (io_master_wvalid_o),
    .sel_lsu_o     (sel_lsu),
    .rtc_req_o     (rtc_req),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_wready_o  (lsu_wready_o),
    .rtc_rvalid_i  (rtc_rvalid)
  );

  bus_lane_align #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_lane_align (
    .sel_lsu_i    (sel_lsu),
    .ifu_araddr_i (ifu_araddr_i),
    .lsu_araddr_i (lsu_araddr_i),
    .lsu_rstrb_i  (lsu_rstrb_i),
    .lsu_awaddr_i (lsu_awaddr_i),
    .lsu_wdata_i  (lsu_wdata_i),
    .lsu_wstrb_i  (lsu_wstrb_i),
    .io_rdata_i   (io_master_rdata_i),
    .rtc_rdata_i  (rtc_rdata),
    .io_araddr_o  (io_master_araddr_o),
    .io_arsize_o  (io_master_arsize_o),
    .io_awaddr_o  (io_master_awaddr_o),
    .io_awsize_o  (io_master_awsize_o),
    .io_wdata_o   (io_master_wdata_o),
    .io_wstrb_o   (io_master_wstrb_o),
    .rdata_o      (rdata),
    .rtc_hit_o    (rtc_hit)
  );

  bus_clint #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_clint (
    .clk       (clk),
    .rst       (rst),
    .araddr_i  (lsu_araddr_i),
    .arvalid_i (rtc_req),
    .rdata_o   (rtc_rdata),
    .rvalid_o  (rtc_rvalid)
  );

endmodule

/* tb_axi_mem.sv */
`timescale 1ns/1ps

module tb_axi_mem #(
  parameter logic [15:0] SEED = 16'd58650
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [63:0] rdata_o,
  output logic [1:0]  rresp_o,
  output logic        rvalid_o,
  input  logic [31:0] awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [63:0] wdata_i,
  input  logic [7:0]  wstrb_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic [1:0]  bresp_o,
  output logic        bvalid_o
);

  localparam logic [63:0] FILL = 64'h5a5a_5a5a_a5a5_a5a5;

  logic [63:0] mem [0:511];  // 4 KiB
  logic [15:0] lfsr;
  logic [1:0]  ar_wait;
  logic [1:0]  aw_wait;
  logic [1:0]  w_wait;
  logic        aw_have;
  logic        w_have;
  logic [8:0]  wr_idx;
  logic [63:0] wr_data;
  logic [7:0]  wr_strb;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic draw_wait(inout logic [15:0] s, output logic [1:0] d);
    for (int b = 0; b < 2; b++)
    begin
      d[b] = s[0];
      s = lfsr_step(s);
    end
  endtask

  assign arready_o = arvalid_i && (ar_wait == 2'd0);
  assign awready_o = awvalid_i && !aw_have && (aw_wait == 2'd0);
  assign wready_o  = wvalid_i && !w_have && (w_wait == 2'd0);
  assign rresp_o   = 2'b00;
  assign bresp_o   = 2'b00;

  always @(posedge clk)
  begin
    logic [15:0] s;
    logic [1:0]  d;
    s = lfsr;
    if (rst)
    begin
      for (int i = 0; i < 512; i++)
        mem[i] <= 64'(i) ^ FILL;
      lfsr     <= SEED;
      ar_wait  <= 2'd0;
      aw_wait  <= 2'd0;
      w_wait   <= 2'd0;
      aw_have  <= 1'b0;
      w_have   <= 1'b0;
      rvalid_o <= 1'b0;
      bvalid_o <= 1'b0;
    end
    else
    begin
      rvalid_o <= 1'b0;
      bvalid_o <= 1'b0;
      if (arvalid_i && arready_o)
      begin
        rdata_o  <= mem[araddr_i[11:3]];  // reply next cycle
        rvalid_o <= 1'b1;
        draw_wait(s, d);
        ar_wait <= d;
      end
      else if (arvalid_i && ar_wait != 2'd0)
        ar_wait <= ar_wait - 2'd1;
      if (awvalid_i && awready_o)
      begin
        wr_idx  <= awaddr_i[11:3];
        aw_have <= 1'b1;
        draw_wait(s, d);
        aw_wait <= d;
      end
      else if (awvalid_i && !aw_have && aw_wait != 2'd0)
        aw_wait <= aw_wait - 2'd1;
      if (wvalid_i && wready_o)
      begin
        wr_data <= wdata_i;
        wr_strb <= wstrb_i;
        w_have  <= 1'b1;
        draw_wait(s, d);
        w_wait <= d;
      end
      else if (wvalid_i && !w_have && w_wait != 2'd0)
        w_wait <= w_wait - 2'd1;
      // both halves in, commit and answer
      if (aw_have && w_have)
      begin
        for (int b = 0; b < 8; b++)
          if (wr_strb[b])
            mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
        aw_have  <= 1'b0;
        w_have   <= 1'b0;
        bvalid_o <= 1'b1;
      end
      lfsr <= s;
    end
  end

endmodule

/* tb_bus_chk.sv */
`timescale 1ns/1ps

module tb_bus_chk (
  input logic        clk,
  input logic        rst,
  input logic        arvalid_i,
  input logic        arready_i,
  input logic [31:0] araddr_i,
  input logic        awvalid_i,
  input logic        awready_i,
  input logic [31:0] awaddr_i,
  input logic        wvalid_i,
  input logic        wready_i,
  input logic [63:0] wdata_i,
  input logic [7:0]  wstrb_i,
  input logic        rvalid_i,
  input logic [1:0]  rresp_i,
  input logic        bvalid_i,
  input logic [1:0]  bresp_i,
  input logic        ifu_rvalid_i,
  input logic        lsu_rvalid_i
);

  ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
    else $error("AR valid or address changed while stalled");

  aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
    else $error("AW valid or address changed while stalled");

  w_hold: assert property (@(posedge clk) disable iff (rst)
    wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
    else $error("W valid or payload changed while stalled");

  rresp_okay: assert property (@(posedge clk) disable iff (rst)
    rvalid_i |-> rresp_i == 2'b00)
    else $error("slave returned a non-zero read response");

  bresp_okay: assert property (@(posedge clk) disable iff (rst)
    bvalid_i |-> bresp_i == 2'b00)
    else $error("slave returned a non-zero write response");

  // one requester per reply
  reply_onehot: assert property (@(posedge clk) disable iff (rst)
    !(ifu_rvalid_i && lsu_rvalid_i))
    else $error("fetch and load replies in the same cycle");

  no_timer_ar: assert property (@(posedge clk) disable iff (rst)
    arvalid_i |-> (araddr_i != bus_pkg::RTC_ADDR) && (araddr_i != bus_pkg::RTC_ADDR_UP))
    else $error("timer address went out on AR");

endmodule

/* tb_bus_top.sv */
`timescale 1ns/1ps

module tb_bus_top;

  localparam int          RST_CYCLES  = 16;
  localparam int          CYC_PER_REC = 200;
  localparam int          PORT_IFU    = 0;
  localparam int          PORT_LOAD   = 1;
  localparam int          PORT_STORE  = 2;
  localparam logic [63:0] FILL        = 64'h5a5a_5a5a_a5a5_a5a5;

  logic        clk;
  logic        rst;
  logic [31:0] ifu_araddr;
  logic        ifu_arvalid;
  logic [31:0] ifu_rdata;
  logic        ifu_rvalid;
  logic [31:0] lsu_araddr;
  logic        lsu_arvalid;
  logic [3:0]  lsu_rstrb;
  logic [31:0] lsu_rdata;
  logic        lsu_rvalid;
  logic [31:0] lsu_awaddr;
  logic        lsu_awvalid;
  logic [31:0] lsu_wdata;
  logic [3:0]  lsu_wstrb;
  logic        lsu_wready;

  // axi master side
  logic [31:0] araddr;
  logic [31:0] awaddr;
  logic        arvalid;
  logic        arready;
  logic        rvalid;
  logic        awvalid;
  logic        awready;
  logic        wvalid;
  logic        wready;
  logic        bvalid;
  logic [63:0] rdata;
  logic [63:0] wdata;
  logic [7:0]  wstrb;
  logic [1:0]  rresp;
  logic [1:0]  bresp;
  logic [1:0]  arburst;
  logic [2:0]  arsize;
  logic [7:0]  arlen;
  logic [3:0]  arid;
  logic        rready;
  logic [1:0]  awburst;
  logic [2:0]  awsize;
  logic [7:0]  awlen;
  logic [3:0]  awid;
  logic        wlast;
  logic        bready;

  // one entry per record
  logic [7:0]  op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [3:0]  strb_q[$];
  logic [31:0] exp_q[$];

  int          n_rec = 0;
  int          n_checks = 0;
  int          n_errors = 0;
  int          ar_count = 0;
  int          cyc = 0;
  logic [31:0] last_rtc = '0;

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (!rst && arvalid && arready)
      ar_count <= ar_count + 1;  // AR handshakes seen
  end

  bus_top #(
    .ADDR_W (32),
    .DATA_W (32)
  ) bus_top_i (
    .clk                 (clk),
    .rst                 (rst),
    .ifu_araddr_i        (ifu_araddr),
    .ifu_arvalid_i       (ifu_arvalid),
    .ifu_rdata_o         (ifu_rdata),
    .ifu_rvalid_o        (ifu_rvalid),
    .lsu_araddr_i        (lsu_araddr),
    .lsu_arvalid_i       (lsu_arvalid),
    .lsu_rstrb_i         (lsu_rstrb),
    .lsu_rdata_o         (lsu_rdata),
    .lsu_rvalid_o        (lsu_rvalid),
    .lsu_awaddr_i        (lsu_awaddr),
    .lsu_awvalid_i       (lsu_awvalid),
    .lsu_wdata_i         (lsu_wdata),
    .lsu_wstrb_i         (lsu_wstrb),
    .lsu_wready_o        (lsu_wready),
    .io_master_arburst_o (arburst),
    .io_master_arsize_o  (arsize),
    .io_master_arlen_o   (arlen),
    .io_master_arid_o    (arid),
    .io_master_araddr_o  (araddr),
    .io_master_arvalid_o (arvalid),
    .io_master_arready_i (arready),
    .io_master_rdata_i   (rdata),
    .io_master_rresp_i   (rresp),
    .io_master_rvalid_i  (rvalid),
    .io_master_rready_o  (rready),
    .io_master_awburst_o (awburst),
    .io_master_awsize_o  (awsize),
    .io_master_awlen_o   (awlen),
    .io_master_awid_o    (awid),
    .io_master_awaddr_o  (awaddr),
    .io_master_awvalid_o (awvalid),
    .io_master_awready_i (awready),
    .io_master_wlast_o   (wlast),
    .io_master_wdata_o   (wdata),
    .io_master_wstrb_o   (wstrb),
    .io_master_wvalid_o  (wvalid),
    .io_master_wready_i  (wready),
    .io_master_bresp_i   (bresp),
    .io_master_bvalid_i  (bvalid),
    .io_master_bready_o  (bready)
  );

  tb_axi_mem axi_mem (
    .clk       (clk),
    .rst       (rst),
    .araddr_i  (araddr),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .rdata_o   (rdata),
    .rresp_o   (rresp),
    .rvalid_o  (rvalid),
    .awaddr_i  (awaddr),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .wdata_i   (wdata),
    .wstrb_i   (wstrb),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .bresp_o   (bresp),
    .bvalid_o  (bvalid)
  );

  bind bus_top tb_bus_chk bus_chk (
    .clk          (clk),
    .rst          (rst),
    .arvalid_i    (io_master_arvalid_o),
    .arready_i    (io_master_arready_i),
    .araddr_i     (io_master_araddr_o),
    .awvalid_i    (io_master_awvalid_o),
    .awready_i    (io_master_awready_i),
    .awaddr_i     (io_master_awaddr_o),
    .wvalid_i     (io_master_wvalid_o),
    .wready_i     (io_master_wready_i),
    .wdata_i      (io_master_wdata_o),
    .wstrb_i      (io_master_wstrb_o),
    .rvalid_i     (io_master_rvalid_i),
    .rresp_i      (io_master_rresp_i),
    .bvalid_i     (io_master_bvalid_i),
    .bresp_i      (io_master_bresp_i),
    .ifu_rvalid_i (ifu_rvalid_o),
    .lsu_rvalid_i (lsu_rvalid_o)
  );

  // initial memory half that a read of addr sees
  function automatic logic [31:0] init_half(input logic [31:0] addr);
    logic [63:0] word;
    word = 64'(addr[11:3]) ^ FILL;
    return addr[2] ? word[63:32] : word[31:0];
  endfunction

  // bytes in the access give the size code
  function automatic logic [2:0] strobe_size(input logic [3:0] strb);
    logic [2:0] size;
    case ($countones(strb))
      1:       size = bus_pkg::AXI_SIZE_B;
      2:       size = bus_pkg::AXI_SIZE_H;
      4:       size = bus_pkg::AXI_SIZE_W;
      default: size = bus_pkg::AXI_SIZE_B;
    endcase
    return size;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    n_checks++;
    if (act !== exp)
    begin
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
      n_errors++;
    end
  endtask

  // single-beat INCR bursts with id 0 and ready responses
  task automatic check_fixed_fields();
    compare_value("io_master_arburst_o", 32'd1, 32'(arburst));
    compare_value("io_master_arlen_o", 32'd0, 32'(arlen));
    compare_value("io_master_arid_o", 32'd0, 32'(arid));
    compare_value("io_master_awburst_o", 32'd1, 32'(awburst));
    compare_value("io_master_awlen_o", 32'd0, 32'(awlen));
    compare_value("io_master_awid_o", 32'd0, 32'(awid));
    compare_value("io_master_wlast_o", 32'd1, 32'(wlast));
    compare_value("io_master_rready_o", 32'd1, 32'(rready));
    compare_value("io_master_bready_o", 32'd1, 32'(bready));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic await_reply(input int port, output logic [31:0] data);
    logic seen;
    seen = 1'b0;
    while (!seen)
    begin
      @(negedge clk);  // outputs settled here
      case (port)
        PORT_IFU:  seen = ifu_rvalid;
        PORT_LOAD: seen = lsu_rvalid;
        default:   seen = lsu_wready;
      endcase
    end
    data = (port == PORT_IFU) ? ifu_rdata : lsu_rdata;
  endtask

  // size codes while an address is offered
  always @(negedge clk)
  begin
    if (!rst && awvalid)
      compare_value("io_master_awsize_o", 32'(strobe_size(lsu_wstrb)), 32'(awsize));
    if (!rst && arvalid)
    begin
      if (lsu_arvalid && araddr == lsu_araddr)
        compare_value("io_master_arsize_o", 32'(strobe_size(lsu_rstrb)), 32'(arsize));
      else
        compare_value("io_master_arsize_o", 32'(bus_pkg::AXI_SIZE_W), 32'(arsize));
    end
  end

  task automatic run_record(input int i);
    logic [31:0] got;
    logic [31:0] got_f;
    int          ar_before;
    int          l_cyc;
    int          f_cyc;
    logic        l_done;
    logic        f_done;
    case (op_q[i])
      "F":
      begin
        ifu_araddr  = addr_q[i];
        ifu_arvalid = 1'b1;
        await_reply(PORT_IFU, got);
        next_cycle();
        ifu_arvalid = 1'b0;
        compare_value("ifu_rdata_o", exp_q[i], got);
      end
      "L":
      begin
        lsu_araddr  = addr_q[i];
        lsu_rstrb   = strb_q[i];
        lsu_arvalid = 1'b1;
        await_reply(PORT_LOAD, got);
        next_cycle();
        lsu_arvalid = 1'b0;
        compare_value("lsu_rdata_o", exp_q[i], got);
      end
      "S":
      begin
        lsu_awaddr  = addr_q[i];
        lsu_wdata   = data_q[i];
        lsu_wstrb   = strb_q[i];
        lsu_awvalid = 1'b1;
        await_reply(PORT_STORE, got);
        next_cycle();
        lsu_awvalid = 1'b0;
      end
      "T":
      begin
        ar_before   = ar_count;
        lsu_araddr  = (addr_q[i] == 32'd0) ? bus_pkg::RTC_ADDR : bus_pkg::RTC_ADDR_UP;
        lsu_rstrb   = 4'hf;
        lsu_arvalid = 1'b1;
        await_reply(PORT_LOAD, got);
        next_cycle();
        lsu_arvalid = 1'b0;
        compare_value("io_master_arvalid_o handshakes", 32'(ar_before), 32'(ar_count));
        if (addr_q[i] == 32'd0)
        begin
          compare_value("lsu_rdata_o above last mtime", 32'd1, {31'd0, got > last_rtc});
          last_rtc = got;
        end
        else
          compare_value("lsu_rdata_o", exp_q[i], got);
      end
      "P":
      begin
        l_done      = 1'b0;
        f_done      = 1'b0;
        l_cyc       = 0;
        f_cyc       = 0;
        lsu_araddr  = addr_q[i];
        lsu_rstrb   = strb_q[i];
        ifu_araddr  = data_q[i];
        lsu_arvalid = 1'b1;
        ifu_arvalid = 1'b1;
        while (lsu_arvalid || ifu_arvalid)
        begin
          @(negedge clk);
          if (lsu_rvalid)
          begin
            l_cyc  = cyc;
            got    = lsu_rdata;
            l_done = 1'b1;
          end
          if (ifu_rvalid)
          begin
            f_cyc  = cyc;
            got_f  = ifu_rdata;
            f_done = 1'b1;
          end
          next_cycle();
          if (l_done)
            lsu_arvalid = 1'b0;
          if (f_done)
            ifu_arvalid = 1'b0;
        end
        compare_value("lsu_rdata_o", exp_q[i], got);
        compare_value("ifu_rdata_o", init_half(data_q[i]), got_f);
        compare_value("lsu_rvalid_o before ifu_rvalid_o", 32'd1, {31'd0, l_cyc < f_cyc});
      end
      default:
      begin
        $display("record %0d has an unknown operation code", i);
        n_errors++;
      end
    endcase
  endtask

  initial
  begin
    int          fd;
    string       line;
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expv;
    logic [3:0]  strb;
    ifu_araddr  = '0;
    ifu_arvalid = 1'b0;
    lsu_araddr  = '0;
    lsu_arvalid = 1'b0;
    lsu_rstrb   = '0;
    lsu_awaddr  = '0;
    lsu_awvalid = 1'b0;
    lsu_wdata   = '0;
    lsu_wstrb   = '0;
    rst         = 1'b1;
    fd = $fopen("tb_input.txt", "r");
    if (fd == 0)
    begin
      $display("could not open tb_input.txt for reading");
      n_errors++;
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        if (line.len() > 1 && line[0] != "#")
        begin
          if ($sscanf(line, "%c %h %h %h %h", op, addr, data, strb, expv) == 5)
          begin
            op_q.push_back(op);
            addr_q.push_back(addr);
            data_q.push_back(data);
            strb_q.push_back(strb);
            exp_q.push_back(expv);
          end
          else
          begin
            $display("could not parse the record line: %s", line);
            n_errors++;
          end
        end
      end
      $fclose(fd);
    end
    n_rec = op_q.size();
    if (n_rec == 0)
    begin
      $display("there were no records to run");
      n_errors++;
    end
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    check_fixed_fields();
    for (int i = 0; i < n_rec; i++)
      run_record(i);
    repeat (4) @(posedge clk);
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  // watchdog scaled by the number of records
  initial
  begin
    wait (n_rec > 0);
    repeat (RST_CYCLES + CYC_PER_REC * n_rec) @(posedge clk);
    $display("timed out after %0d cycles waiting for a reply", cyc);
    $display("tests failed");
    $finish;
  end

endmodule

/* tb_input.txt */
# op addr data strb expect (hex); F fetch, L load, S store, T timer, P load+fetch
# T: addr 0 low word (must rise), 4 high word; P: data is the fetch address
F 80000000 00000000 f a5a5a5a5
F 80000104 00000000 f 5a5a5a5a
F 80000010 00000000 f a5a5a5a7
S 80000200 12345678 f 00000000
L 80000200 00000000 f 12345678
S 80000204 deadbeef f 00000000
L 80000204 00000000 f deadbeef
S 80000301 000000ab 1 00000000
S 80000302 0000cdef 3 00000000
L 80000300 00000000 f cdefabc5
S 8000030f 00000077 1 00000000
S 8000030d 00001122 3 00000000
L 8000030c 00000000 f 7711225a
T 00000000 00000000 f 00000000
T 00000004 00000000 f 00000000
T 00000000 00000000 f 00000000
P 80000200 80000018 f 12345678
